/* commit_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module commit_stage (
  input  wire                           clock,
  input  wire                           reset,
  // Retiring instruction
  input  wire                           commit_valid,
  output logic                          commit_ready,
  input  wire rv_commit_pkg::word_t     commit_pc,
  input  wire rv_commit_pkg::word_t     commit_npc,
  input  wire rv_commit_pkg::reg_addr_t rd,
  input  wire                           rd_wen,
  input  wire rv_commit_pkg::word_t     rd_wdata,
  input  wire rv_commit_pkg::csr_addr_t csr_waddr,
  input  wire                           csr_wen,
  input  wire rv_commit_pkg::word_t     csr_wdata,
  input  wire                           ecall,
  input  wire                           misaligned,
  input  wire                           mret,
  input  wire                           fence_i,
  input  wire                           mispredict,
  // Retire record
  output logic                          retire_valid,
  input  wire                           retire_ready,
  output rv_commit_pkg::word_t          retire_pc,
  output rv_commit_pkg::word_t          retire_npc,
  output logic                          flush,
  output logic                          flush_icache,
  // Decode read ports
  input  wire rv_commit_pkg::reg_addr_t rs1,
  input  wire rv_commit_pkg::reg_addr_t rs2,
  output rv_commit_pkg::word_t          src1,
  output rv_commit_pkg::word_t          src2,
  input  wire rv_commit_pkg::csr_addr_t csr_raddr,
  output rv_commit_pkg::word_t          csr_rdata
);

  import rv_commit_pkg::*;

  logic  gpr_wen;
  logic  csr_wen_ok;
  logic  trap_take;
  word_t trap_cause;
  word_t trap_pc;
  word_t mtvec;
  word_t mepc;

  gpr_file gpr_file_inst (
    .clock (clock),
    .reset (reset),
    .rs1   (rs1),
    .rs2   (rs2),
    .src1  (src1),
    .src2  (src2),
    .wen   (gpr_wen),
    .rd    (rd),
    .wdata (rd_wdata)
  );

  csr_file csr_file_inst (
    .clock      (clock),
    .reset      (reset),
    .raddr      (csr_raddr),
    .rdata      (csr_rdata),
    .wen        (csr_wen_ok),
    .waddr      (csr_waddr),
    .wdata      (csr_wdata),
    .trap_take  (trap_take),
    .trap_cause (trap_cause),
    .trap_pc    (trap_pc),
    .mtvec      (mtvec),
    .mepc       (mepc)
  );

  retire_controller retire_controller_inst (
    .clock        (clock),
    .reset        (reset),
    .commit_valid (commit_valid),
    .commit_ready (commit_ready),
    .commit_pc    (commit_pc),
    .commit_npc   (commit_npc),
    .rd_wen       (rd_wen),
    .csr_wen      (csr_wen),
    .ecall        (ecall),
    .misaligned   (misaligned),
    .mret         (mret),
    .fence_i      (fence_i),
    .mispredict   (mispredict),
    .mtvec        (mtvec),
    .mepc         (mepc),
    .gpr_wen      (gpr_wen),
    .csr_wen_ok   (csr_wen_ok),
    .trap_take    (trap_take),
    .trap_cause   (trap_cause),
    .trap_pc      (trap_pc),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready),
    .retire_pc    (retire_pc),
    .retire_npc   (retire_npc),
    .flush        (flush),
    .flush_icache (flush_icache)
  );

endmodule

`default_nettype wire

/* commit_stage_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_defs.svh"

module commit_stage_tb;

  import rv_commit_pkg::*;

  localparam int FIELDS      = 10;
  localparam int MAX_VECTORS = 64;

  logic      clock;
  logic      reset;
  logic      commit_valid;
  logic      commit_ready;
  word_t     commit_pc;
  word_t     commit_npc;
  reg_addr_t rd;
  logic      rd_wen;
  word_t     rd_wdata;
  csr_addr_t csr_waddr;
  logic      csr_wen;
  word_t     csr_wdata;
  logic      ecall;
  logic      misaligned;
  logic      mret;
  logic      fence_i;
  logic      mispredict;
  logic      retire_valid;
  logic      retire_ready;
  word_t     retire_pc;
  word_t     retire_npc;
  logic      flush;
  logic      flush_icache;
  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t     src1;
  word_t     src2;
  csr_addr_t csr_raddr;
  word_t     csr_rdata;

  word_t       vec_mem [FIELDS*MAX_VECTORS];
  int          num_vectors;
  int          cycle_count;
  int          cycle_limit;
  logic [31:0] lcg_state;

  // Model of the one-entry output buffer
  logic model_accepted;
  logic model_consumed;
  logic record_held;

  // Expected retire records with the oldest at the front
  word_t exp_pc_q[$];
  word_t exp_npc_q[$];
  logic  exp_flush_q[$];
  logic  exp_icache_q[$];
  int    exp_vec_q[$];

  commit_stage commit_stage_inst (.*);

  always #20 clock = ~clock;

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  function automatic logic [31:0] next_lcg(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic stop_with_failure();
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Fail %s: expected %b, actual %b", name, expected, actual);
      stop_with_failure();
    end
  endtask

  // Each operation starts 2 ns after a rising edge and ends at the next such slot
  task automatic read_gpr(input reg_addr_t idx, input word_t expected, input string name);
    rs1 = idx;
    rs2 = idx;
    @(negedge clock);
    check_word({name, " src1"}, expected, src1);
    check_word({name, " src2"}, expected, src2);
    @(posedge clock);
    #2;
  endtask

  task automatic read_csr(input csr_addr_t addr, input word_t expected, input string name);
    csr_raddr = addr;
    @(negedge clock);
    check_word(name, expected, csr_rdata);
    @(posedge clock);
    #2;
  endtask

  task automatic run_commit(input int v);
    word_t flags;
    int    b;
    b          = v * FIELDS;
    flags      = vec_mem[b+7];
    commit_pc  = vec_mem[b+1];
    commit_npc = vec_mem[b+2];
    rd         = vec_mem[b+3][3:0];
    rd_wdata   = vec_mem[b+4];
    csr_waddr  = vec_mem[b+5][11:0];
    csr_wdata  = vec_mem[b+6];
    {rd_wen, csr_wen, ecall, misaligned, mret, fence_i, mispredict} = flags[6:0];
    commit_valid = 1'b1;
    @(negedge clock);
    while (!commit_ready) @(negedge clock);
    // Accepted on the coming edge
    exp_pc_q.push_back(commit_pc);
    exp_npc_q.push_back(vec_mem[b+8]);
    exp_flush_q.push_back(vec_mem[b+9][1]);
    exp_icache_q.push_back(vec_mem[b+9][0]);
    exp_vec_q.push_back(v);
    @(posedge clock);
    #2;
    commit_valid = 1'b0;
    {rd_wen, csr_wen, ecall, misaligned, mret, fence_i, mispredict} = 7'b0;
  endtask

  // ----------------------------------------------------------------------
  // Back-pressure, retire monitor and cycle limit
  // ----------------------------------------------------------------------

  always @(posedge clock) begin
    #2;
    lcg_state = next_lcg(lcg_state);
    // Ready withheld about one cycle in four
    retire_ready = (lcg_state[31:30] != 2'b00);
  end

  // A record appears one cycle after acceptance and leaves when consumed
  always @(posedge clock) begin
    if (reset) begin
      record_held = 1'b0;
    end else begin
      model_accepted = commit_valid && (!record_held || retire_ready);
      model_consumed = record_held && retire_ready;
      record_held    = model_accepted || (record_held && !model_consumed);
    end
  end

  always @(negedge clock) begin
    if (!reset) begin
      check_flag("retire_valid", record_held, retire_valid);
      check_flag("commit_ready", !record_held || retire_ready, commit_ready);
      if (record_held && retire_ready) begin
        check_word($sformatf("vector %0d retire_pc", exp_vec_q[0]),
                   exp_pc_q.pop_front(), retire_pc);
        check_word($sformatf("vector %0d retire_npc", exp_vec_q[0]),
                   exp_npc_q.pop_front(), retire_npc);
        check_flag($sformatf("vector %0d flush", exp_vec_q[0]),
                   exp_flush_q.pop_front(), flush);
        check_flag($sformatf("vector %0d flush_icache", exp_vec_q[0]),
                   exp_icache_q.pop_front(), flush_icache);
        void'(exp_vec_q.pop_front());
      end
    end
  end

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("Run hung: the vectors did not finish within %0d cycles", cycle_limit);
      stop_with_failure();
    end
  end

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    clock        = 1'b0;
    reset        = 1'b1;
    commit_valid = 1'b0;
    commit_pc    = '0;
    commit_npc   = '0;
    rd           = '0;
    rd_wdata     = '0;
    csr_waddr    = '0;
    csr_wdata    = '0;
    {rd_wen, csr_wen, ecall, misaligned, mret, fence_i, mispredict} = 7'b0;
    retire_ready = 1'b1;
    rs1          = '0;
    rs2          = '0;
    csr_raddr    = '0;
    lcg_state    = 32'h70f2_3bc1;
    cycle_count  = 0;
    cycle_limit  = 0;

    $readmemh("commit_stage_vectors.txt", vec_mem);
    num_vectors = 0;
    while (num_vectors < MAX_VECTORS && vec_mem[num_vectors*FIELDS] != 32'hf) begin
      num_vectors++;
    end
    if (num_vectors == 0) begin
      $display("No vectors were read from commit_stage_vectors.txt");
      stop_with_failure();
    end
    cycle_limit = 40 * num_vectors + 200;

    repeat (16) @(posedge clock);
    #2;
    reset = 1'b0;

    // Reset state
    check_flag("reset retire_valid", 1'b0, retire_valid);
    check_flag("reset flush", 1'b0, flush);
    check_flag("reset flush_icache", 1'b0, flush_icache);
    for (int i = 0; i < `RV_NUM_REGS; i++) begin
      read_gpr(reg_addr_t'(i), '0, $sformatf("reset x%0d", i));
    end
    read_csr(`CSR_MSTATUS, `MSTATUS_RESET, "reset mstatus");
    read_csr(`CSR_MTVEC, '0, "reset mtvec");
    read_csr(`CSR_MEPC, '0, "reset mepc");
    read_csr(`CSR_MCAUSE, '0, "reset mcause");
    read_csr(`CSR_MVENDORID, `MVENDORID_VALUE, "mvendorid");
    read_csr(`CSR_MARCHID, `MARCHID_VALUE, "marchid");

    for (int v = 0; v < num_vectors; v++) begin
      case (vec_mem[v*FIELDS])
        32'h0: run_commit(v);
        32'h1: read_gpr(vec_mem[v*FIELDS+3][3:0], vec_mem[v*FIELDS+8],
                        $sformatf("vector %0d register read", v));
        32'h2: read_csr(vec_mem[v*FIELDS+5][11:0], vec_mem[v*FIELDS+8],
                        $sformatf("vector %0d CSR read", v));
        32'h3: begin
          repeat (vec_mem[v*FIELDS+8]) @(posedge clock);
          #2;
        end
        default: begin
          $display("Vector %0d has an unknown operation code", v);
          stop_with_failure();
        end
      endcase
    end

    // Drain the scoreboard, then watch for stray records
    while (exp_npc_q.size() != 0) @(posedge clock);
    repeat (4) @(posedge clock);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* commit_stage_vectors.txt */
// op: 0 commit, 1 register read, 2 CSR read, 3 stall, f end; exp is npc, read value or cycles
// flags: 40 rd_wen 20 csr_wen 10 ecall 08 misaligned 04 mret 02 fence_i 01 mispredict
// op pc       npc      rd rd_wdata csr csr_wdata flags exp      exp_fl (2 flush, 1 icache)
0    00000100 00000104 1  deadbeef 000 00000000 40    00000104 0
0    00000104 00000108 2  12345678 000 00000000 40    00000108 0
0    00000108 0000010c 0  ffffffff 000 00000000 40    0000010c 0
1    00000000 00000000 1  00000000 000 00000000 00    deadbeef 0
1    00000000 00000000 2  00000000 000 00000000 00    12345678 0
1    00000000 00000000 0  00000000 000 00000000 00    00000000 0
0    0000010c 00000110 0  00000000 305 00000800 20    00000110 0
0    00000110 00000114 0  00000000 341 00000200 20    00000114 0
0    00000114 00000118 0  00000000 300 00000088 20    00000118 0
0    00000118 0000011c 0  00000000 342 000000aa 20    0000011c 0
0    0000011c 00000120 0  00000000 f11 11111111 20    00000120 0
2    00000000 00000000 0  00000000 305 00000000 00    00000800 0
2    00000000 00000000 0  00000000 341 00000000 00    00000200 0
2    00000000 00000000 0  00000000 300 00000000 00    00000088 0
2    00000000 00000000 0  00000000 342 00000000 00    00000000 0
2    00000000 00000000 0  00000000 f11 00000000 00    79737978 0
3    00000000 00000000 0  00000000 000 00000000 00    00000003 0
0    00000120 00000124 3  55555555 000 00000000 50    00000800 2
2    00000000 00000000 0  00000000 341 00000000 00    00000120 0
2    00000000 00000000 0  00000000 342 00000000 00    0000000b 0
1    00000000 00000000 3  00000000 000 00000000 00    00000000 0
0    00000802 00000806 4  00000066 305 00000900 68    00000800 2
2    00000000 00000000 0  00000000 342 00000000 00    00000000 0
2    00000000 00000000 0  00000000 305 00000000 00    00000800 0
0    00000800 00000804 0  00000000 000 00000000 04    00000802 2
0    00000802 00000806 5  00000077 000 00000000 42    00000806 3
0    00000806 00000900 0  00000000 000 00000000 01    00000900 2
1    00000000 00000000 5  00000000 000 00000000 00    00000077 0
0    00000900 00000904 6  00000099 000 00000000 58    00000800 2
2    00000000 00000000 0  00000000 342 00000000 00    0000000b 0
f    00000000 00000000 0  00000000 000 00000000 00    00000000 0

/* csr_file.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_defs.svh"

module csr_file (
  input  wire                        clock,
  input  wire                        reset,
  input  wire rv_commit_pkg::csr_addr_t raddr,
  output rv_commit_pkg::word_t       rdata,
  input  wire                        wen,
  input  wire rv_commit_pkg::csr_addr_t waddr,
  input  wire rv_commit_pkg::word_t  wdata,
  input  wire                        trap_take,
  input  wire rv_commit_pkg::word_t  trap_cause,
  input  wire rv_commit_pkg::word_t  trap_pc,
  output rv_commit_pkg::word_t       mtvec,
  output rv_commit_pkg::word_t       mepc
);

  import rv_commit_pkg::*;

  word_t mstatus;
  word_t mcause;

  // ----------------------------------------------------------------------
  // Read port
  // ----------------------------------------------------------------------

  always_comb begin
    case (raddr)
      `CSR_MSTATUS:   rdata = mstatus;
      `CSR_MTVEC:     rdata = mtvec;
      `CSR_MEPC:      rdata = mepc;
      `CSR_MCAUSE:    rdata = mcause;
      `CSR_MVENDORID: rdata = `MVENDORID_VALUE;
      `CSR_MARCHID:   rdata = `MARCHID_VALUE;
      default:        rdata = '0;
    endcase
  end

  // ----------------------------------------------------------------------
  // Update
  // ----------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      mstatus <= `MSTATUS_RESET;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (trap_take) begin
      // Trap capture has priority over a software write
      mepc   <= trap_pc;
      mcause <= trap_cause;
    end else if (wen) begin
      // mcause changes only on a trap and the ID registers never change
      case (waddr)
        `CSR_MSTATUS: mstatus <= wdata;
        `CSR_MTVEC:   mtvec   <= wdata;
        `CSR_MEPC:    mepc    <= wdata;
        default: ;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  // The retire controller suppresses CSR writes on trapping instructions
  no_write_on_trap: assert property (
    @(posedge clock) disable iff (reset)
    !(wen && trap_take)
  );

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
rv_commit_pkg.sv
gpr_file.sv
csr_file.sv
retire_controller.sv
commit_stage.sv
commit_stage_tb.sv

/* gpr_file.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_defs.svh"

module gpr_file (
  input  wire                       clock,
  input  wire                       reset,
  input  wire rv_commit_pkg::reg_addr_t rs1,
  input  wire rv_commit_pkg::reg_addr_t rs2,
  output rv_commit_pkg::word_t      src1,
  output rv_commit_pkg::word_t      src2,
  input  wire                       wen,
  input  wire rv_commit_pkg::reg_addr_t rd,
  input  wire rv_commit_pkg::word_t wdata
);

  import rv_commit_pkg::*;

  word_t regs [`RV_NUM_REGS];

  // Read ports seen by decode in the same cycle
  assign src1 = regs[rs1];
  assign src2 = regs[rs2];

  // ----------------------------------------------------------------------
  // Write port
  // ----------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (rd != '0)) begin
      // x0 keeps its reset value forever
      regs[rd] <= wdata;
    end
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  x0_reads_zero: assert property (
    @(posedge clock) disable iff (reset)
    (rs1 == '0) |-> (src1 == '0)
  );

endmodule

`default_nettype wire

/* retire_controller.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_defs.svh"

module retire_controller (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       commit_valid,
  output logic                      commit_ready,
  input  wire rv_commit_pkg::word_t commit_pc,
  input  wire rv_commit_pkg::word_t commit_npc,
  input  wire                       rd_wen,
  input  wire                       csr_wen,
  input  wire                       ecall,
  input  wire                       misaligned,
  input  wire                       mret,
  input  wire                       fence_i,
  input  wire                       mispredict,
  input  wire rv_commit_pkg::word_t mtvec,
  input  wire rv_commit_pkg::word_t mepc,
  output logic                      gpr_wen,
  output logic                      csr_wen_ok,
  output logic                      trap_take,
  output rv_commit_pkg::word_t      trap_cause,
  output rv_commit_pkg::word_t      trap_pc,
  output logic                      retire_valid,
  input  wire                       retire_ready,
  output rv_commit_pkg::word_t      retire_pc,
  output rv_commit_pkg::word_t      retire_npc,
  output logic                      flush,
  output logic                      flush_icache
);

  import rv_commit_pkg::*;

  logic  accept;
  logic  trap;
  word_t next_npc;
  logic  next_flush;
  logic  next_flush_icache;

  // One-entry buffer takes a new instruction when empty or draining
  assign commit_ready = !retire_valid || retire_ready;
  assign accept       = commit_valid && commit_ready;
  assign trap         = ecall || misaligned;

  // ----------------------------------------------------------------------
  // Write gating and trap request
  // ----------------------------------------------------------------------

  assign gpr_wen    = accept && rd_wen && !trap;
  assign csr_wen_ok = accept && csr_wen && !trap;
  assign trap_take  = accept && trap;
  assign trap_pc    = commit_pc;

  // ecall wins when both trap flags are raised
  assign trap_cause = ecall ? `CAUSE_ECALL : `CAUSE_MISALIGNED;

  // ----------------------------------------------------------------------
  // Next PC and flush selection, in priority order
  // ----------------------------------------------------------------------

  always_comb begin
    next_npc          = commit_npc;
    next_flush        = 1'b0;
    next_flush_icache = 1'b0;
    if (trap) begin
      next_npc   = mtvec;
      next_flush = 1'b1;
    end else if (mret) begin
      next_npc   = mepc;
      next_flush = 1'b1;
    end else if (fence_i) begin
      next_flush        = 1'b1;
      next_flush_icache = 1'b1;
    end else if (mispredict) begin
      next_flush = 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Retire record
  // ----------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      retire_valid <= 1'b0;
      flush        <= 1'b0;
      flush_icache <= 1'b0;
    end else if (accept) begin
      retire_valid <= 1'b1;
      flush        <= next_flush;
      flush_icache <= next_flush_icache;
    end else if (retire_ready) begin
      retire_valid <= 1'b0;
      flush        <= 1'b0;
      flush_icache <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      retire_pc  <= commit_pc;
      retire_npc <= next_npc;
    end
  end

  // Record must hold while the consumer stalls
  record_stable: assert property (
    @(posedge clock) disable iff (reset)
    (retire_valid && !retire_ready) |=>
      (retire_valid && $stable({retire_pc, retire_npc, flush, flush_icache}))
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/bash
# Build and run the commit stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -f flist.f --top-module commit_stage_tb \
  -o commit_stage_sim > build.log 2>&1 \
  && ./obj_dir/commit_stage_sim > sim.log 2>&1

grep -q "^ALL CHECKS PASSED$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

/* rv_commit_pkg.sv */
`default_nettype none

`include "rv_defs.svh"

package rv_commit_pkg;

  // Data and address word
  typedef logic [`RV_XLEN-1:0] word_t;

  // 4-bit register index for the RV32E register count
  typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_addr_t;

  // CSR address
  typedef logic [`CSR_ADDR_WIDTH-1:0] csr_addr_t;

endpackage

`default_nettype wire

/* rv_defs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Datapath sizes
`define RV_XLEN          32
`define RV_NUM_REGS      16
`define CSR_ADDR_WIDTH   12

// Machine-mode CSR addresses
`define CSR_MSTATUS      12'h300
`define CSR_MTVEC        12'h305
`define CSR_MEPC         12'h341
`define CSR_MCAUSE       12'h342
`define CSR_MVENDORID    12'hF11
`define CSR_MARCHID      12'hF12

// Trap cause codes written to mcause
`define CAUSE_MISALIGNED 32'd0
`define CAUSE_ECALL      32'd11

// Reset and identification values
`define MSTATUS_RESET    32'h0000_1800
`define MVENDORID_VALUE  32'h7973_7978
`define MARCHID_VALUE    32'h017D_9F58

`endif
